// File: uart_pkg.sv
// UART package with character and divisor widths, oversampling, frame layout, FIFO depth, FSM codes
`default_nettype none

package uart_pkg;

	// Character width
	localparam int DATA_W = 8;
	// Baud divisor width
	localparam int BAUD_W = 20;

	// Ticks per serial bit
	localparam int OVERSAMPLE = 4;
	localparam int OS_SHIFT = $clog2(OVERSAMPLE);

	// Start bit, data bits and stop bit
	localparam int FRAME_BITS = DATA_W + 2;
	localparam int FRAME_TICKS = FRAME_BITS * OVERSAMPLE;
	localparam int BIT_IDX_W = $clog2(FRAME_BITS);

	// Tick counter must reach FRAME_TICKS
	localparam int TICK_CNT_W = $clog2(FRAME_TICKS + 1);
	// Received data bit counter
	localparam int BIT_CNT_W = $clog2(DATA_W);

	// Transmit FIFO size and initial host credits
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// Last tick of a transmitted frame
	localparam logic [TICK_CNT_W-1:0] TX_LAST_TICK = TICK_CNT_W'(FRAME_TICKS - 1);
	// Receiver tick counts for mid start bit and bit period
	localparam logic [TICK_CNT_W-1:0] RX_MID_TICK = TICK_CNT_W'(OVERSAMPLE / 2 - 1);
	localparam logic [TICK_CNT_W-1:0] RX_BIT_TICK = TICK_CNT_W'(OVERSAMPLE - 1);
	localparam logic [BIT_CNT_W-1:0] RX_LAST_BIT = BIT_CNT_W'(DATA_W - 1);

	// Transmitter FSM
	localparam logic TX_IDLE = 1'b0;
	localparam logic TX_WORKING = 1'b1;

	// Receiver FSM
	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA = 2'd2;
	localparam logic [1:0] RX_STOP = 2'd3;

endpackage

`default_nettype wire

// File: uart_baud_gen.sv
// Baud generator module producing the oversampling tick from a run-time divisor
`timescale 1ns/100ps
`default_nettype none

module uart_baud_gen (
	input wire iCLOCK,
	input wire inRESET,
	// Tick period is baud_div+1 clocks
	input wire [uart_pkg::BAUD_W-1:0] baud_div,
	output logic tick
);

	// Free-running divisor counter
	logic [uart_pkg::BAUD_W-1:0] div_cnt;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else begin
			// Wrap also covers a divisor lowered below the current count
			if (div_cnt >= baud_div) begin
				div_cnt <= '0;
				tick <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
				// Tick lasts a single clock
				tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: uart_tx_fifo.sv
// Transmit FIFO module with credit return on every pop
`timescale 1ns/100ps
`default_nettype none

module uart_tx_fifo (
	input wire iCLOCK,
	input wire inRESET,
	// Host side, one push per credit held
	input wire push,
	input wire [uart_pkg::DATA_W-1:0] push_data,
	// Transmitter side
	input wire fifo_pop,
	output logic fifo_valid,
	output logic [uart_pkg::DATA_W-1:0] fifo_data,
	// One pulse per freed entry
	output logic credit_return
);

	// Byte storage
	logic [uart_pkg::DATA_W-1:0] mem [uart_pkg::FIFO_DEPTH];
	// Pointers wrap naturally at the power of two depth
	logic [uart_pkg::FIFO_AW-1:0] wr_ptr;
	logic [uart_pkg::FIFO_AW-1:0] rd_ptr;
	// Occupancy, one bit wider to hold a full FIFO
	logic [uart_pkg::FIFO_AW:0] count;
	// Pop only counts when an entry is present
	logic do_pop;

	assign do_pop = fifo_pop && (count != '0);

	// Storage write
	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers, occupancy and credit pulse
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count unchanged
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Credit goes back the cycle after the pop
			credit_return <= do_pop;
		end
	end

	// Head of queue toward the transmitter
	assign fifo_valid = (count != '0);
	assign fifo_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: uart_transmitter.sv
// UART transmitter module serializing 8N1 frames on the oversampling tick
`timescale 1ns/100ps
`default_nettype none

module uart_transmitter (
	input wire iCLOCK,
	input wire inRESET,
	// Oversampling enable
	input wire tick,
	// FIFO head
	input wire fifo_valid,
	input wire [uart_pkg::DATA_W-1:0] fifo_data,
	output logic fifo_pop,
	// Serial line
	output logic txd,
	output logic tx_busy
);

	logic state;
	// Ticks elapsed in the current frame
	logic [uart_pkg::TICK_CNT_W-1:0] tick_cnt;
	// Byte taken from the FIFO
	logic [uart_pkg::DATA_W-1:0] tx_data;
	// Stop bit still on the line after the FSM went idle
	logic stop_tail;
	// Full frame, bit 0 goes first
	logic [uart_pkg::FRAME_BITS-1:0] frame;
	// Current bit position in the frame
	logic [uart_pkg::BIT_IDX_W-1:0] bit_idx;

	// Take the next byte whenever idle
	assign fifo_pop = (state == uart_pkg::TX_IDLE) && fifo_valid;

	// Stop, data LSB first, start
	assign frame = {1'b1, tx_data, 1'b0};
	// Divide by the oversampling factor
	assign bit_idx = tick_cnt[uart_pkg::TICK_CNT_W-1:uart_pkg::OS_SHIFT];

	assign tx_busy = (state == uart_pkg::TX_WORKING) || stop_tail;

	// Data latch
	always_ff @(posedge iCLOCK) begin
		if (fifo_pop) begin
			tx_data <= fifo_data;
		end
	end

	// Frame sequencing
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= uart_pkg::TX_IDLE;
			tick_cnt <= '0;
			txd <= 1'b1;
			stop_tail <= 1'b0;
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					if (fifo_pop) begin
						// Line stays high until the next tick
						state <= uart_pkg::TX_WORKING;
						tick_cnt <= '0;
						stop_tail <= 1'b0;
					end else if (tick) begin
						// Last stop bit period done
						stop_tail <= 1'b0;
					end
				end
				uart_pkg::TX_WORKING: begin
					if (tick) begin
						// New line level on every tick
						txd <= frame[bit_idx];
						if (tick_cnt == uart_pkg::TX_LAST_TICK) begin
							// Stop bit now driven, finishes during idle
							state <= uart_pkg::TX_IDLE;
							stop_tail <= 1'b1;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				default: begin
					state <= uart_pkg::TX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uart_receiver.sv
// UART receiver module with input synchronizer, start check, mid-bit sampling and stop check
`timescale 1ns/100ps
`default_nettype none

module uart_receiver (
	input wire iCLOCK,
	input wire inRESET,
	// Oversampling enable
	input wire tick,
	// Asynchronous serial input
	input wire rxd,
	// Received byte toward the host
	output logic [uart_pkg::DATA_W-1:0] rx_data,
	output logic rx_valid,
	output logic rx_frame_error
);

	// Two-flop synchronizer
	logic rxd_meta;
	logic rxd_sync;
	logic [1:0] state;
	// Ticks inside the current bit
	logic [uart_pkg::TICK_CNT_W-1:0] tick_cnt;
	// Data bits received so far
	logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
	// Data shift register, LSB arrives first
	logic [uart_pkg::DATA_W-1:0] shift;
	// Mid-bit sample strobes
	logic bit_end;
	logic data_sample;
	logic stop_sample;

	assign bit_end = tick && (tick_cnt == uart_pkg::RX_BIT_TICK);
	assign data_sample = (state == uart_pkg::RX_DATA) && bit_end;
	assign stop_sample = (state == uart_pkg::RX_STOP) && bit_end;

	// Payload path
	always_ff @(posedge iCLOCK) begin
		if (data_sample) begin
			shift <= {rxd_sync, shift[uart_pkg::DATA_W-1:1]};
		end
		if (stop_sample) begin
			rx_data <= shift;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			// Idle line is high
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			state <= uart_pkg::RX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
			rx_frame_error <= 1'b0;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rx_valid <= 1'b0;
			// Report byte and stop level together
			if (stop_sample) begin
				rx_valid <= 1'b1;
				rx_frame_error <= !rxd_sync;
			end
			if (tick) begin
				case (state)
					uart_pkg::RX_IDLE: begin
						// Low line means a start bit begins
						if (!rxd_sync) begin
							state <= uart_pkg::RX_START;
							tick_cnt <= '0;
						end
					end
					uart_pkg::RX_START: begin
						if (tick_cnt == uart_pkg::RX_MID_TICK) begin
							tick_cnt <= '0;
							bit_cnt <= '0;
							// High at mid start is a glitch, drop silently
							if (rxd_sync) begin
								state <= uart_pkg::RX_IDLE;
							end else begin
								state <= uart_pkg::RX_DATA;
							end
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					uart_pkg::RX_DATA: begin
						if (tick_cnt == uart_pkg::RX_BIT_TICK) begin
							tick_cnt <= '0;
							bit_cnt <= bit_cnt + 1'b1;
							// Eighth bit taken
							if (bit_cnt == uart_pkg::RX_LAST_BIT) begin
								state <= uart_pkg::RX_STOP;
							end
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					uart_pkg::RX_STOP: begin
						// Back to idle at mid stop bit
						if (tick_cnt == uart_pkg::RX_BIT_TICK) begin
							tick_cnt <= '0;
							state <= uart_pkg::RX_IDLE;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					default: begin
						state <= uart_pkg::RX_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: uart_top.sv
// UART top module connecting baud generator, transmit FIFO, transmitter and receiver
`timescale 1ns/100ps
`default_nettype none

module uart_top (
	input wire iCLOCK,
	input wire inRESET,
	// Change only while both directions are idle
	input wire [uart_pkg::BAUD_W-1:0] baud_div,
	// Host transmit side under credit flow control
	input wire push,
	input wire [uart_pkg::DATA_W-1:0] push_data,
	output logic credit_return,
	// Serial transmit
	output logic txd,
	output logic tx_busy,
	// Serial receive
	input wire rxd,
	output logic [uart_pkg::DATA_W-1:0] rx_data,
	output logic rx_valid,
	output logic rx_frame_error
);

	// Shared oversampling enable
	logic tick;
	// FIFO to transmitter
	logic fifo_valid;
	logic [uart_pkg::DATA_W-1:0] fifo_data;
	logic fifo_pop;

	uart_baud_gen u_baud_gen (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.baud_div(baud_div),
		.tick(tick)
	);

	uart_tx_fifo u_tx_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.push(push),
		.push_data(push_data),
		.fifo_pop(fifo_pop),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data),
		.credit_return(credit_return)
	);

	uart_transmitter u_transmitter (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.tick(tick),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data),
		.fifo_pop(fifo_pop),
		.txd(txd),
		.tx_busy(tx_busy)
	);

	// Same tick as the transmitter
	uart_receiver u_receiver (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.tick(tick),
		.rxd(rxd),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_frame_error(rx_frame_error)
	);

endmodule

`default_nettype wire

// File: tb_uart_top.sv
// Testbench module for uart_top with loopback, credit tracking, framing error and glitch checks
`timescale 1ns/100ps
`default_nettype none

module tb_uart_top;

	typedef struct packed {
		logic [19:0] div;
		logic [7:0] data;
		logic loopback;
		logic stop_bit;
		logic [7:0] exp_data;
		logic exp_ferr;
	} entry_t;

	localparam int N_ENTRIES = 10;

	logic iCLOCK;
	logic inRESET;
	logic [uart_pkg::BAUD_W-1:0] baud_div;
	logic push;
	logic [uart_pkg::DATA_W-1:0] push_data;
	wire credit_return;
	wire txd;
	wire tx_busy;
	wire rxd;
	wire [uart_pkg::DATA_W-1:0] rx_data;
	wire rx_valid;
	wire rx_frame_error;

	// Loopback select and bit-banged line
	logic loop_sel;
	logic bb_rxd;
	entry_t tab [N_ENTRIES];
	// Expected {frame error, byte} in arrival order
	logic [8:0] exp_q [$];
	int pushes;
	int returns;
	int min_credits;
	int cycles;
	int limit;

	assign rxd = loop_sel ? txd : bb_rxd;

	uart_top DUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.baud_div(baud_div),
		.push(push),
		.push_data(push_data),
		.credit_return(credit_return),
		.txd(txd),
		.tx_busy(tx_busy),
		.rxd(rxd),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_frame_error(rx_frame_error)
	);

	always #10 iCLOCK = ~iCLOCK;

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Step to just after the next rising edge
	task automatic next_cycle();
		@(posedge iCLOCK);
		#1;
	endtask

	// Push one byte, stalling while no credit is held
	task automatic push_byte(input logic [7:0] b);
		int credits;
		while (uart_pkg::FIFO_DEPTH - pushes + returns == 0) begin
			next_cycle();
		end
		push = 1'b1;
		push_data = b;
		next_cycle();
		push = 1'b0;
		pushes = pushes + 1;
		credits = uart_pkg::FIFO_DEPTH - pushes + returns;
		if (credits < min_credits) begin
			min_credits = credits;
		end
	endtask

	// Loopback burst of entries first to last-1, all at one divisor
	task automatic send_group(input int first, input int last);
		int low_cycles;
		int gap;
		loop_sel = 1'b1;
		min_credits = uart_pkg::FIFO_DEPTH;
		for (int k = first; k < last; k++) begin
			exp_q.push_back({tab[k].exp_ferr, tab[k].exp_data});
		end
		push_byte(tab[first].data);
		// First byte has LSB set so the start bit is the only low run
		low_cycles = 0;
		while (txd) begin
			next_cycle();
		end
		while (!txd) begin
			low_cycles = low_cycles + 1;
			next_cycle();
		end
		check_value("start bit cycles", 32'(low_cycles),
			32'(uart_pkg::OVERSAMPLE * (int'(tab[first].div) + 1)));
		for (int k = first + 1; k < last; k++) begin
			gap = int'($urandom % 3);
			repeat (gap) next_cycle();
			push_byte(tab[k].data);
		end
		if (last - first > uart_pkg::FIFO_DEPTH) begin
			check_value("lowest credit count", 32'(min_credits), 32'd0);
		end
		while (exp_q.size() != 0 || tx_busy) begin
			next_cycle();
		end
	endtask

	// Bit-banged frame with a chosen stop level
	task automatic inject_frame(input int i);
		logic [9:0] bits;
		loop_sel = 1'b0;
		bits = {tab[i].stop_bit, tab[i].data, 1'b0};
		exp_q.push_back({tab[i].exp_ferr, tab[i].exp_data});
		for (int k = 0; k < 10; k++) begin
			bb_rxd = bits[k];
			repeat (uart_pkg::OVERSAMPLE * (int'(tab[i].div) + 1)) next_cycle();
		end
		bb_rxd = 1'b1;
		while (exp_q.size() != 0) begin
			next_cycle();
		end
	endtask

	// Received byte against the oldest expected one
	always @(posedge iCLOCK) begin
		if (rx_valid) begin
			if (exp_q.size() == 0) begin
				$display("received a byte at time %0t when none was expected", $time);
				$display("tests failed");
				$fatal(1);
			end else begin
				check_value("rx_data", 32'(rx_data), 32'(exp_q[0][7:0]));
				check_value("rx_frame_error", 32'(rx_frame_error), 32'(exp_q[0][8]));
				void'(exp_q.pop_front());
			end
		end
	end

	// Credits back from the FIFO
	always @(posedge iCLOCK) begin
		if (credit_return) begin
			returns = returns + 1;
		end
	end

	// Run length guard
	always @(posedge iCLOCK) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles with the run still going", cycles);
			$display("tests failed");
			$fatal(1);
		end
	end

	initial begin
		int i;
		int j;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		baud_div = 20'd3;
		push = 1'b0;
		push_data = 8'h00;
		loop_sel = 1'b1;
		bb_rxd = 1'b1;
		pushes = 0;
		returns = 0;
		min_credits = uart_pkg::FIFO_DEPTH;
		cycles = 0;
		void'($urandom(32'h9adc));
		// div, byte, loopback, stop level, expected byte, expected frame error
		tab[0] = '{20'd3, 8'ha5, 1'b1, 1'b1, 8'ha5, 1'b0};
		tab[1] = '{20'd3, 8'h3c, 1'b1, 1'b1, 8'h3c, 1'b0};
		tab[2] = '{20'd3, 8'h00, 1'b1, 1'b1, 8'h00, 1'b0};
		tab[3] = '{20'd3, 8'hff, 1'b1, 1'b1, 8'hff, 1'b0};
		tab[4] = '{20'd3, 8'h5a, 1'b1, 1'b1, 8'h5a, 1'b0};
		tab[5] = '{20'd5, 8'h81, 1'b1, 1'b1, 8'h81, 1'b0};
		tab[6] = '{20'd5, 8'h7e, 1'b1, 1'b1, 8'h7e, 1'b0};
		tab[7] = '{20'd7, 8'hc3, 1'b1, 1'b1, 8'hc3, 1'b0};
		tab[8] = '{20'd3, 8'h96, 1'b0, 1'b0, 8'h96, 1'b1};
		tab[9] = '{20'd3, 8'h4b, 1'b0, 1'b1, 8'h4b, 1'b0};
		limit = 200;
		for (int k = 0; k < N_ENTRIES; k++) begin
			limit = limit + uart_pkg::FRAME_TICKS * (int'(tab[k].div) + 1);
		end
		repeat (3) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		// Idle outputs after reset
		repeat (4) begin
			check_value("txd", 32'(txd), 32'd1);
			check_value("tx_busy", 32'(tx_busy), 32'd0);
			check_value("rx_valid", 32'(rx_valid), 32'd0);
			check_value("rx_frame_error", 32'(rx_frame_error), 32'd0);
			check_value("credit_return", 32'(credit_return), 32'd0);
			next_cycle();
		end
		i = 0;
		while (i < N_ENTRIES) begin
			// Divisor changes only with both directions idle
			baud_div = tab[i].div;
			if (tab[i].loopback) begin
				j = i;
				while (j < N_ENTRIES && tab[j].loopback && tab[j].div == tab[i].div) begin
					j = j + 1;
				end
				send_group(i, j);
				i = j;
			end else begin
				inject_frame(i);
				i = i + 1;
			end
		end
		// Low pulse of one tick period dies before mid start
		loop_sel = 1'b0;
		bb_rxd = 1'b0;
		repeat (int'(baud_div) + 1) next_cycle();
		bb_rxd = 1'b1;
		// Long enough for a wrongly accepted start to reach its stop bit
		repeat (uart_pkg::FRAME_TICKS * (int'(baud_div) + 1)) next_cycle();
		check_value("credits returned", 32'(returns), 32'(pushes));
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
uart_pkg.sv
uart_baud_gen.sv
uart_tx_fifo.sv
uart_transmitter.sv
uart_receiver.sv
uart_top.sv
tb_uart_top.sv

// File: run.sh
#!/bin/sh
# Build the UART testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary -f vlog.f --top-module tb_uart_top -o sim_uart \
	&& ./obj_dir/sim_uart | grep -x "all tests passed" \
	|| exit 1
